// File: wb_defs.svh
`ifndef WB_DEFS_SVH
`define WB_DEFS_SVH

// datapath and register address widths
`define WB_XLEN 32
`define WB_RA_W 5

// start strobe to done strobe
`define WB_DIV_CYCLES 33

// exception codes
`define WB_EXC_INT  7'h00
`define WB_EXC_PIL  7'h01
`define WB_EXC_PIS  7'h02
`define WB_EXC_PIF  7'h03
`define WB_EXC_PME  7'h04
`define WB_EXC_PPI  7'h07
`define WB_EXC_ADEF 7'h08
`define WB_EXC_ALE  7'h09
`define WB_EXC_TLBR 7'h3f

`endif

// File: wb_pkg.sv
`include "wb_defs.svh"

package wb_pkg;

    // kind of uop sitting in each lane
    typedef enum logic [2:0] {
        UOP_NONE,
        UOP_ALU,
        UOP_LINK,
        UOP_CSR,
        UOP_DIV_Q,
        UOP_DIV_R,
        UOP_LOAD
    } uop_kind_e;

    typedef enum logic [6:0] {
        EXC_INT  = `WB_EXC_INT,
        EXC_PIL  = `WB_EXC_PIL,
        EXC_PIS  = `WB_EXC_PIS,
        EXC_PIF  = `WB_EXC_PIF,
        EXC_PME  = `WB_EXC_PME,
        EXC_PPI  = `WB_EXC_PPI,
        EXC_ADEF = `WB_EXC_ADEF,
        EXC_ALE  = `WB_EXC_ALE,
        EXC_TLBR = `WB_EXC_TLBR
    } exc_code_e;

endpackage

// File: wb_lane.sv
`timescale 1ns/10ps
`include "wb_defs.svh"

module wb_lane (
    input  logic                 clk,
    input  logic                 aresetn,
    input  logic                 valid,
    input  wb_pkg::uop_kind_e    kind,
    input  logic [`WB_RA_W-1:0]  rd,
    input  logic [`WB_XLEN-1:0]  result,
    input  logic [`WB_XLEN-1:0]  csr_data,
    input  logic                 csr_ready,
    input  logic [`WB_XLEN-1:0]  quotient,
    input  logic [`WB_XLEN-1:0]  remainder,
    input  logic                 div_ready,
    input  logic [`WB_XLEN-1:0]  load_data,
    input  logic [`WB_RA_W-1:0]  load_rd,
    input  logic                 load_ready,
    output logic                 we,
    output logic [`WB_RA_W-1:0]  waddr,
    output logic [`WB_XLEN-1:0]  wdata,
    output logic                 stall
);

    logic                sel_we;
    logic [`WB_RA_W-1:0] sel_addr;
    logic [`WB_XLEN-1:0] sel_data;

    // source select, waiting uops raise stall and write nothing
    always_comb begin
        sel_we   = 1'b0;
        sel_addr = rd;
        sel_data = result;
        stall    = 1'b0;
        if (valid) begin
            case (kind)
                wb_pkg::UOP_ALU: begin
                    sel_we = 1'b1;
                end
                wb_pkg::UOP_LINK: begin
                    sel_we   = 1'b1;
                    sel_data = result + `WB_XLEN'd4;
                end
                wb_pkg::UOP_CSR: begin
                    sel_we   = csr_ready;
                    sel_data = csr_data;
                    stall    = !csr_ready;
                end
                wb_pkg::UOP_DIV_Q: begin
                    sel_we   = div_ready;
                    sel_data = quotient;
                    stall    = !div_ready;
                end
                wb_pkg::UOP_DIV_R: begin
                    sel_we   = div_ready;
                    sel_data = remainder;
                    stall    = !div_ready;
                end
                wb_pkg::UOP_LOAD: begin
                    // load returns carry their own destination
                    sel_we   = load_ready;
                    sel_addr = load_rd;
                    sel_data = load_data;
                    stall    = !load_ready;
                end
                default: begin
                    sel_we = 1'b0;
                end
            endcase
        end
    end

    always_ff @(posedge clk or negedge aresetn) begin
        if (!aresetn) begin
            we <= 1'b0;
        end else begin
            we <= sel_we;
        end
    end

    always_ff @(posedge clk) begin
        if (sel_we) begin
            waddr <= sel_addr;
            wdata <= sel_data;
        end
    end

    // an empty slot never produces a register write
    assert property (@(posedge clk) disable iff (!aresetn)
        we |-> $past(kind) != wb_pkg::UOP_NONE);

endmodule

// File: div_unit.sv
`timescale 1ns/10ps
`include "wb_defs.svh"

module div_unit (
    input  logic                clk,
    input  logic                aresetn,
    input  logic                start,
    input  logic [`WB_XLEN-1:0] dividend,
    input  logic [`WB_XLEN-1:0] divisor,
    output logic [`WB_XLEN-1:0] quotient,
    output logic [`WB_XLEN-1:0] remainder,
    output logic                done
);

    logic [`WB_XLEN-1:0]   rem_q;
    logic [`WB_XLEN-1:0]   quo_q;
    logic [`WB_XLEN-1:0]   dvs_q;
    logic [5:0]            cnt;
    logic                  busy;
    logic                  last;
    logic [2*`WB_XLEN-1:0] first_step;
    logic [2*`WB_XLEN-1:0] next_step;

    // one restoring step: shift in the next dividend bit, try the subtract
    function automatic logic [2*`WB_XLEN-1:0] div_step(
        input logic [`WB_XLEN-1:0] rem,
        input logic [`WB_XLEN-1:0] quo,
        input logic [`WB_XLEN-1:0] dvs
    );
        logic [`WB_XLEN:0] shifted;
        logic [`WB_XLEN:0] diff;
        shifted = {rem, quo[`WB_XLEN-1]};
        diff    = shifted - {1'b0, dvs};
        if (diff[`WB_XLEN]) begin
            return {shifted[`WB_XLEN-1:0], quo[`WB_XLEN-2:0], 1'b0};
        end
        return {diff[`WB_XLEN-1:0], quo[`WB_XLEN-2:0], 1'b1};
    endfunction

    // dividend bits shift out of quo_q while quotient bits shift in
    assign first_step = div_step('0, dividend, divisor);
    assign next_step  = div_step(rem_q, quo_q, dvs_q);

    // step count reaches 32 in the cycle that moves results to the outputs
    assign last = busy && (cnt == 6'(`WB_DIV_CYCLES - 1));

    always_ff @(posedge clk or negedge aresetn) begin
        if (!aresetn) begin
            busy <= 1'b0;
            cnt  <= '0;
            done <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start) begin
                busy <= 1'b1;
                cnt  <= 6'd1;
            end else if (busy) begin
                cnt <= cnt + 6'd1;
                if (last) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end
        end
    end

    // zero divisor falls out as all-ones quotient, remainder = dividend
    always_ff @(posedge clk) begin
        if (start) begin
            {rem_q, quo_q} <= first_step;
            dvs_q          <= divisor;
        end else if (busy && !last) begin
            {rem_q, quo_q} <= next_step;
        end
        if (last) begin
            quotient  <= quo_q;
            remainder <= rem_q;
        end
    end

    assert property (@(posedge clk) disable iff (!aresetn)
        start |-> !busy);

    assert property (@(posedge clk) disable iff (!aresetn)
        done |=> !done);

endmodule

// File: wb_regfile.sv
`timescale 1ns/10ps
`include "wb_defs.svh"

module wb_regfile (
    input  logic                clk,
    input  logic                aresetn,
    input  logic                we0,
    input  logic [`WB_RA_W-1:0] waddr0,
    input  logic [`WB_XLEN-1:0] wdata0,
    input  logic                we1,
    input  logic [`WB_RA_W-1:0] waddr1,
    input  logic [`WB_XLEN-1:0] wdata1,
    input  logic [`WB_RA_W-1:0] raddr0,
    input  logic [`WB_RA_W-1:0] raddr1,
    output logic [`WB_XLEN-1:0] rdata0,
    output logic [`WB_XLEN-1:0] rdata1
);

    logic [`WB_XLEN-1:0] regs [2**`WB_RA_W];

    always_ff @(posedge clk or negedge aresetn) begin
        if (!aresetn) begin
            for (int i = 0; i < 2**`WB_RA_W; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (we0 && waddr0 != '0) begin
                regs[waddr0] <= wdata0;
            end
            // lane 1 is younger, so it lands last
            if (we1 && waddr1 != '0) begin
                regs[waddr1] <= wdata1;
            end
        end
    end

    assign rdata0 = (raddr0 == '0) ? '0 : regs[raddr0];
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];

endmodule

// File: exc_commit.sv
`timescale 1ns/10ps
`include "wb_defs.svh"

module exc_commit (
    input  logic                clk,
    input  logic                aresetn,
    input  logic                exc_valid,
    input  wb_pkg::exc_code_e   ecode,
    input  logic [`WB_XLEN-1:0] badv,
    input  logic [`WB_XLEN-1:0] era,
    input  logic                interrupt,
    input  logic [`WB_XLEN-1:0] eentry,
    input  logic [`WB_XLEN-1:0] tlbrentry,
    output logic                flush,
    output logic [6:0]          ecode_out,
    output logic [`WB_XLEN-1:0] badv_out,
    output logic                wen_badv,
    output logic [18:0]         vppn_out,
    output logic                wen_vppn,
    output logic [`WB_XLEN-1:0] era_out,
    output logic                wen_era,
    output logic [`WB_XLEN-1:0] redirect_pc
);

    logic set_badv;
    logic set_vppn;
    logic tlb_refill;

    // page faults and refill record the page number, address errors do not
    assign set_vppn = ecode inside {wb_pkg::EXC_PIL, wb_pkg::EXC_PIS, wb_pkg::EXC_PIF,
                                    wb_pkg::EXC_PME, wb_pkg::EXC_PPI, wb_pkg::EXC_TLBR};
    assign set_badv = set_vppn || ecode inside {wb_pkg::EXC_ADEF, wb_pkg::EXC_ALE};

    always_ff @(posedge clk or negedge aresetn) begin
        if (!aresetn) begin
            flush      <= 1'b0;
            wen_era    <= 1'b0;
            wen_badv   <= 1'b0;
            wen_vppn   <= 1'b0;
            tlb_refill <= 1'b0;
        end else begin
            flush      <= exc_valid || interrupt;
            wen_era    <= exc_valid || interrupt;
            wen_badv   <= exc_valid && set_badv;
            wen_vppn   <= exc_valid && set_vppn;
            tlb_refill <= exc_valid && ecode == wb_pkg::EXC_TLBR;
        end
    end

    always_ff @(posedge clk) begin
        ecode_out <= exc_valid ? ecode : wb_pkg::EXC_INT;
        badv_out  <= badv;
        vppn_out  <= badv[`WB_XLEN-1:13];
        era_out   <= era;
    end

    assign redirect_pc = tlb_refill ? tlbrentry : eentry;

    assert property (@(posedge clk) disable iff (!aresetn)
        wen_vppn |-> wen_badv && $past(exc_valid));

endmodule

// File: wb_top.sv
`timescale 1ns/10ps
`include "wb_defs.svh"

module wb_top (
    input  logic                clk,
    input  logic                aresetn,
    input  logic                lane0_valid,
    input  wb_pkg::uop_kind_e   lane0_kind,
    input  logic [`WB_RA_W-1:0] lane0_rd,
    input  logic [`WB_XLEN-1:0] lane0_result,
    input  logic                lane1_valid,
    input  wb_pkg::uop_kind_e   lane1_kind,
    input  logic [`WB_RA_W-1:0] lane1_rd,
    input  logic [`WB_XLEN-1:0] lane1_result,
    input  logic [`WB_XLEN-1:0] csr_data,
    input  logic                csr_ready,
    input  logic [`WB_XLEN-1:0] load_data,
    input  logic [`WB_RA_W-1:0] load_rd,
    input  logic                load_ready,
    input  logic                div_start,
    input  logic [`WB_XLEN-1:0] div_dividend,
    input  logic [`WB_XLEN-1:0] div_divisor,
    input  logic                exc_valid,
    input  wb_pkg::exc_code_e   ecode,
    input  logic [`WB_XLEN-1:0] badv,
    input  logic [`WB_XLEN-1:0] era,
    input  logic                interrupt,
    input  logic [`WB_XLEN-1:0] eentry,
    input  logic [`WB_XLEN-1:0] tlbrentry,
    input  logic [`WB_RA_W-1:0] rf_raddr0,
    input  logic [`WB_RA_W-1:0] rf_raddr1,
    output logic [`WB_XLEN-1:0] rf_rdata0,
    output logic [`WB_XLEN-1:0] rf_rdata1,
    output logic                wb_allowin,
    output logic                div_busy_done,
    output logic                flush,
    output logic [6:0]          ecode_out,
    output logic [`WB_XLEN-1:0] badv_out,
    output logic                wen_badv,
    output logic [18:0]         vppn_out,
    output logic                wen_vppn,
    output logic [`WB_XLEN-1:0] era_out,
    output logic                wen_era,
    output logic [`WB_XLEN-1:0] redirect_pc
);

    logic [`WB_XLEN-1:0] quotient;
    logic [`WB_XLEN-1:0] remainder;
    logic                we0;
    logic                we1;
    logic [`WB_RA_W-1:0] waddr0;
    logic [`WB_RA_W-1:0] waddr1;
    logic [`WB_XLEN-1:0] wdata0;
    logic [`WB_XLEN-1:0] wdata1;
    logic                stall0;
    logic                stall1;

    // hold the upstream pair while either lane waits on a source
    assign wb_allowin = !(stall0 || stall1);

    wb_lane u_lane0 (
        .clk(clk), .aresetn(aresetn),
        .valid(lane0_valid), .kind(lane0_kind), .rd(lane0_rd), .result(lane0_result),
        .csr_data(csr_data), .csr_ready(csr_ready),
        .quotient(quotient), .remainder(remainder), .div_ready(div_busy_done),
        .load_data(load_data), .load_rd(load_rd), .load_ready(load_ready),
        .we(we0), .waddr(waddr0), .wdata(wdata0), .stall(stall0)
    );

    wb_lane u_lane1 (
        .clk(clk), .aresetn(aresetn),
        .valid(lane1_valid), .kind(lane1_kind), .rd(lane1_rd), .result(lane1_result),
        .csr_data(csr_data), .csr_ready(csr_ready),
        .quotient(quotient), .remainder(remainder), .div_ready(div_busy_done),
        .load_data(load_data), .load_rd(load_rd), .load_ready(load_ready),
        .we(we1), .waddr(waddr1), .wdata(wdata1), .stall(stall1)
    );

    div_unit u_div (
        .clk(clk), .aresetn(aresetn),
        .start(div_start), .dividend(div_dividend), .divisor(div_divisor),
        .quotient(quotient), .remainder(remainder), .done(div_busy_done)
    );

    wb_regfile u_regfile (
        .clk(clk), .aresetn(aresetn),
        .we0(we0), .waddr0(waddr0), .wdata0(wdata0),
        .we1(we1), .waddr1(waddr1), .wdata1(wdata1),
        .raddr0(rf_raddr0), .raddr1(rf_raddr1),
        .rdata0(rf_rdata0), .rdata1(rf_rdata1)
    );

    exc_commit u_exc (
        .clk(clk), .aresetn(aresetn),
        .exc_valid(exc_valid), .ecode(ecode), .badv(badv), .era(era),
        .interrupt(interrupt), .eentry(eentry), .tlbrentry(tlbrentry),
        .flush(flush), .ecode_out(ecode_out),
        .badv_out(badv_out), .wen_badv(wen_badv),
        .vppn_out(vppn_out), .wen_vppn(wen_vppn),
        .era_out(era_out), .wen_era(wen_era),
        .redirect_pc(redirect_pc)
    );

endmodule

// File: tb_clk_gen.sv
`timescale 1ns/10ps

module tb_clk_gen (
    output logic clk
);

    // 8 ns period
    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk;
        end
    end

endmodule

// File: tb_wb_top.sv
`timescale 1ns/10ps
`include "wb_defs.svh"

module tb_wb_top;

    localparam int n_alu = 40;
    localparam int n_gate = 60;
    localparam int n_div = 8;
    localparam int n_exc = 24;
    localparam int n_int = 12;
    localparam int total_cycles = 2 + 3 * n_alu + n_gate + 17
                                  + n_div * (`WB_DIV_CYCLES + 3) + 2 * n_exc + n_int + 1;

    logic clk, aresetn;
    logic lane0_valid, lane1_valid;
    wb_pkg::uop_kind_e lane0_kind, lane1_kind;
    logic [4:0] lane0_rd, lane1_rd, load_rd, rf_raddr0, rf_raddr1;
    logic [31:0] lane0_result, lane1_result, csr_data, load_data, div_dividend, div_divisor;
    logic csr_ready, load_ready, div_start, exc_valid, interrupt;
    wb_pkg::exc_code_e ecode;
    logic [31:0] badv, era, eentry, tlbrentry, rf_rdata0, rf_rdata1;
    logic wb_allowin, div_busy_done, flush, wen_badv, wen_vppn, wen_era;
    logic [6:0] ecode_out;
    logic [31:0] badv_out, era_out, redirect_pc;
    logic [18:0] vppn_out;

    logic [31:0] lfsr, exp_q, exp_r, dvd, dvs;
    logic [31:0] model [32];
    wb_pkg::exc_code_e codes [9];
    logic s0, s1;
    int errors, checks, tests, mark, n, idx;

    tb_clk_gen u_clk_gen (.clk(clk));

    wb_top u_wb_top (.*);

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] rand_bits(input int nbits);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < nbits; i++) begin
            lfsr = lfsr_step(lfsr);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    // codes that carry a bad address
    // page_only leaves out the two address errors
    function automatic logic addr_exc(input wb_pkg::exc_code_e c, input logic page_only);
        case (c)
            wb_pkg::EXC_PIL, wb_pkg::EXC_PIS, wb_pkg::EXC_PIF, wb_pkg::EXC_PME,
            wb_pkg::EXC_PPI, wb_pkg::EXC_TLBR: return 1'b1;
            wb_pkg::EXC_ADEF, wb_pkg::EXC_ALE: return !page_only;
            default: return 1'b0;
        endcase
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %s: got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    task automatic lanes_idle();
        lane0_valid = 1'b0;
        lane1_valid = 1'b0;
    endtask

    // reference write-back for one lane in program order
    task automatic model_lane(input logic v, input wb_pkg::uop_kind_e k, input logic [4:0] rd,
                              input logic [31:0] res, input logic dready, output logic stall);
        logic wr;
        logic [4:0] a;
        logic [31:0] d;
        wr = 1'b0;
        a = rd;
        d = res;
        stall = 1'b0;
        if (v) begin
            case (k)
                wb_pkg::UOP_ALU: wr = 1'b1;
                wb_pkg::UOP_LINK: begin
                    wr = 1'b1;
                    d = res + 32'd4;
                end
                wb_pkg::UOP_CSR: begin
                    wr = csr_ready;
                    d = csr_data;
                end
                wb_pkg::UOP_DIV_Q: begin
                    wr = dready;
                    d = exp_q;
                end
                wb_pkg::UOP_DIV_R: begin
                    wr = dready;
                    d = exp_r;
                end
                wb_pkg::UOP_LOAD: begin
                    wr = load_ready;
                    a = load_rd;
                    d = load_data;
                end
                default: wr = 1'b0;
            endcase
            stall = !wr && k != wb_pkg::UOP_NONE && k != wb_pkg::UOP_ALU
                    && k != wb_pkg::UOP_LINK;
        end
        if (wr && a != 5'd0) begin
            model[a] = d;
        end
    endtask

    task automatic read_check(input logic [4:0] a0, input logic [4:0] a1);
        rf_raddr0 = a0;
        rf_raddr1 = a1;
        #1;
        check("rf_rdata0", rf_rdata0, model[a0]);
        check("rf_rdata1", rf_rdata1, model[a1]);
        tick();
    endtask

    task automatic report_test(input string name, input int start_errors);
        tests++;
        if (errors == start_errors) begin
            $display("%s: passed", name);
        end else begin
            $display("%s: failed with %0d errors", name, errors - start_errors);
        end
    endtask

    initial begin
        #(total_cycles * 8 + 500);
        $display("timeout: the run went past its cycle budget");
        $display("TEST FAIL");
        $finish;
    end

    initial begin
        aresetn = 1'b0;
        lanes_idle();
        lane0_kind = wb_pkg::UOP_NONE;
        lane1_kind = wb_pkg::UOP_NONE;
        {lane0_rd, lane1_rd, load_rd, rf_raddr0, rf_raddr1} = '0;
        {lane0_result, lane1_result, csr_data, load_data} = '0;
        {div_dividend, div_divisor, badv, era, eentry, tlbrentry} = '0;
        {csr_ready, load_ready, div_start, exc_valid, interrupt} = '0;
        ecode = wb_pkg::EXC_INT;
        codes = '{wb_pkg::EXC_INT, wb_pkg::EXC_PIL, wb_pkg::EXC_PIS, wb_pkg::EXC_PIF,
                  wb_pkg::EXC_PME, wb_pkg::EXC_PPI, wb_pkg::EXC_ADEF, wb_pkg::EXC_ALE,
                  wb_pkg::EXC_TLBR};
        lfsr = 32'h2152b2b3;
        {errors, checks, tests, exp_q, exp_r} = '0;
        for (int i = 0; i < 32; i++) begin
            model[i] = '0;
        end
        repeat (2) @(posedge clk);
        #1;
        aresetn = 1'b1;

        mark = errors;
        for (int i = 0; i < n_alu; i++) begin
            lane0_valid = 1'b1;
            lane1_valid = 1'b1;
            lane0_kind = rand_bits(1) ? wb_pkg::UOP_LINK : wb_pkg::UOP_ALU;
            lane1_kind = rand_bits(1) ? wb_pkg::UOP_LINK : wb_pkg::UOP_ALU;
            lane0_rd = (rand_bits(3) == 0) ? 5'd0 : 5'(rand_bits(5));
            lane1_rd = (rand_bits(2) == 0) ? lane0_rd : 5'(rand_bits(5));
            lane0_result = rand_bits(32);
            lane1_result = rand_bits(32);
            model_lane(1'b1, lane0_kind, lane0_rd, lane0_result, 1'b0, s0);
            model_lane(1'b1, lane1_kind, lane1_rd, lane1_result, 1'b0, s1);
            tick();
            lanes_idle();
            tick();
            read_check(lane0_rd, lane1_rd);
        end
        report_test("alu and link writes", mark);

        mark = errors;
        for (int i = 0; i < n_gate; i++) begin
            lane0_valid = 1'(rand_bits(1));
            lane1_valid = 1'(rand_bits(1));
            lane0_kind = wb_pkg::uop_kind_e'(rand_bits(3) % 7);
            lane1_kind = wb_pkg::uop_kind_e'(rand_bits(3) % 7);
            lane0_rd = 5'(rand_bits(5));
            lane1_rd = 5'(rand_bits(5));
            lane0_result = rand_bits(32);
            lane1_result = rand_bits(32);
            csr_ready = 1'(rand_bits(1));
            csr_data = rand_bits(32);
            load_ready = 1'(rand_bits(1));
            load_data = rand_bits(32);
            load_rd = 5'(rand_bits(5));
            model_lane(lane0_valid, lane0_kind, lane0_rd, lane0_result, 1'b0, s0);
            model_lane(lane1_valid, lane1_kind, lane1_rd, lane1_result, 1'b0, s1);
            #1;
            check("wb_allowin", wb_allowin, !(s0 || s1));
            tick();
        end
        lanes_idle();
        tick();
        for (int i = 0; i < 16; i++) begin
            read_check(5'(2 * i), 5'(2 * i + 1));
        end
        report_test("csr and load gating", mark);

        mark = errors;
        for (int i = 0; i < n_div; i++) begin
            dvd = rand_bits(32);
            dvs = (rand_bits(2) == 0) ? 32'd0 : rand_bits(32) >> rand_bits(5);
            // divide by zero gives all ones and the dividend back
            if (dvs == 0) begin
                exp_q = '1;
                exp_r = dvd;
            end else begin
                exp_q = dvd / dvs;
                exp_r = dvd % dvs;
            end
            div_dividend = dvd;
            div_divisor = dvs;
            div_start = 1'b1;
            lane0_valid = 1'b1;
            lane1_valid = 1'b1;
            lane0_kind = wb_pkg::UOP_DIV_Q;
            lane1_kind = wb_pkg::UOP_DIV_R;
            lane0_rd = 5'(rand_bits(5));
            lane1_rd = 5'(rand_bits(5));
            tick();
            div_start = 1'b0;
            n = 1;
            while (!div_busy_done && n < 2 * `WB_DIV_CYCLES) begin
                check("wb_allowin", wb_allowin, 1'b0);
                tick();
                n++;
            end
            if (!div_busy_done) begin
                errors++;
                $display("divider done strobe never arrived for divide %0d", i);
            end else begin
                check("div_busy_done latency", n, `WB_DIV_CYCLES);
                check("wb_allowin", wb_allowin, 1'b1);
            end
            model_lane(1'b1, lane0_kind, lane0_rd, 32'd0, 1'b1, s0);
            model_lane(1'b1, lane1_kind, lane1_rd, 32'd0, 1'b1, s1);
            tick();
            check("div_busy_done", div_busy_done, 1'b0);
            lanes_idle();
            tick();
            read_check(lane0_rd, lane1_rd);
        end
        report_test("divider", mark);

        mark = errors;
        eentry = rand_bits(32);
        tlbrentry = rand_bits(32);
        for (int i = 0; i < n_exc; i++) begin
            idx = int'(rand_bits(4) % 9);
            exc_valid = 1'b1;
            ecode = codes[idx];
            badv = rand_bits(32);
            era = rand_bits(32);
            tick();
            exc_valid = 1'b0;
            check("flush", flush, 1'b1);
            check("wen_era", wen_era, 1'b1);
            check("era_out", era_out, era);
            check("ecode_out", ecode_out, ecode);
            check("wen_badv", wen_badv, addr_exc(ecode, 1'b0));
            check("wen_vppn", wen_vppn, addr_exc(ecode, 1'b1));
            if (addr_exc(ecode, 1'b0)) begin
                check("badv_out", badv_out, badv);
            end
            if (addr_exc(ecode, 1'b1)) begin
                check("vppn_out", vppn_out, badv[31:13]);
            end
            check("redirect_pc", redirect_pc,
                  (ecode == wb_pkg::EXC_TLBR) ? tlbrentry : eentry);
            tick();
            check("flush", flush, 1'b0);
            check("wen_era", wen_era, 1'b0);
            check("wen_badv", wen_badv, 1'b0);
            check("wen_vppn", wen_vppn, 1'b0);
        end
        report_test("exception registration", mark);

        mark = errors;
        for (int i = 0; i < n_int; i++) begin
            if (rand_bits(1)) begin
                interrupt = 1'b1;
                exc_valid = 1'b0;
                ecode = codes[int'(rand_bits(4) % 9)];
            end else begin
                interrupt = 1'b0;
                exc_valid = 1'b1;
                ecode = wb_pkg::EXC_TLBR;
            end
            era = rand_bits(32);
            badv = rand_bits(32);
            tick();
            check("flush", flush, 1'b1);
            check("wen_era", wen_era, 1'b1);
            check("era_out", era_out, era);
            check("ecode_out", ecode_out, interrupt ? `WB_EXC_INT : `WB_EXC_TLBR);
            check("wen_badv", wen_badv, !interrupt);
            check("wen_vppn", wen_vppn, !interrupt);
            check("redirect_pc", redirect_pc, interrupt ? eentry : tlbrentry);
        end
        interrupt = 1'b0;
        exc_valid = 1'b0;
        tick();
        report_test("interrupt and redirect", mark);

        $display("tests: %0d  checks: %0d  errors: %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// File: verilog.f
+incdir+.
wb_pkg.sv
wb_lane.sv
div_unit.sv
wb_regfile.sv
exc_commit.sv
wb_top.sv
tb_clk_gen.sv
tb_wb_top.sv
